//--- jpeg_out_pkg.sv
/*
 * Shared widths, capacity constants and the RAM address type of the
 * JPEG output reorder buffer. Imported by every module of the buffer.
 */
package jpeg_out_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int DATA_W       = 32;
    localparam int SAMPLE_IDX_W = 6;
    localparam int SLOT_W       = 2;
    localparam int RAM_ADDR_W   = SLOT_W + SAMPLE_IDX_W;

    // ----------------------------------------
    // Capacity
    // ----------------------------------------
    localparam int RAM_DEPTH = 1 << RAM_ADDR_W;

    // One stored chroma sample is read four times in 4:2:0 mode
    localparam int CX_UPSAMPLE      = 4;
    localparam int CX_OUT_PER_BLOCK = CX_UPSAMPLE * (1 << SAMPLE_IDX_W);

    // Full RAM in 4:2:0 mode gives 1024 outputs still to deliver
    localparam int LEVEL_MAX = RAM_DEPTH * CX_UPSAMPLE;
    localparam int LEVEL_W   = $clog2(LEVEL_MAX) + 1;

    // ----------------------------------------
    // RAM address
    // ----------------------------------------
    typedef struct packed {
        logic [SLOT_W-1:0]       slot;
        logic [SAMPLE_IDX_W-1:0] sample;
    } blk_addr_t;

    // Same address word, seen as a flat pointer or as slot and sample
    typedef union packed {
        logic [RAM_ADDR_W-1:0] linear;
        blk_addr_t             blk;
    } ram_addr_t;

endpackage

//--- jpeg_rd_if.sv
/*
 * Read path of the output buffer: fetch strobe, accept, read address,
 * RAM read data and the current level, with one modport per block.
 */
`timescale 1ns/1ps

interface jpeg_rd_if import jpeg_out_pkg::*; ();

    logic                fetch;
    logic                accept;
    ram_addr_t           rd_addr;
    logic [DATA_W-1:0]   rd_data;
    logic [LEVEL_W-1:0]  level;

    modport level_mp (
        input  accept,
        output level
    );

    modport addr_mp (
        input  fetch,
        output rd_addr
    );

    modport ram_mp (
        input  fetch,
        input  rd_addr,
        output rd_data
    );

    modport out_mp (
        output fetch,
        output accept,
        input  rd_data,
        input  level
    );

endinterface

//--- jpeg_out_level.sv
/*
 * Count of output words still to be delivered. A push adds one, or four
 * in 4:2:0 mode, and every accepted output word removes one.
 */
`timescale 1ns/1ps

module jpeg_out_level import jpeg_out_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        push_i,
    input  logic        mode420_i,
    input  logic        flush_i,
    jpeg_rd_if.level_mp rd
);

    logic [LEVEL_W-1:0] level_q;
    logic [LEVEL_W-1:0] push_inc;
    logic [LEVEL_W-1:0] level_next;

    always_comb
    begin
        push_inc = '0;
        if (push_i)
            push_inc = mode420_i ? LEVEL_W'(CX_UPSAMPLE) : LEVEL_W'(1);

        level_next = level_q + push_inc - LEVEL_W'(rd.accept);
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i || flush_i)
            level_q <= '0;
        else
            level_q <= level_next;
    end

    assign rd.level = level_q;

    // Output stage must never accept a word that was not counted in
    a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
        rd.accept |-> rd.level != '0);

    // Writer has no back-pressure, so overfilling is a caller error
    a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
        push_i && !flush_i |=> rd.level <= LEVEL_W'(LEVEL_MAX));

endmodule

//--- jpeg_out_rd_addr.sv
/*
 * Read address generator. Linear mode walks the RAM in write order,
 * 4:2:0 mode reads each 8x8 chroma block as a 16x16 upsampled block.
 */
`timescale 1ns/1ps

module jpeg_out_rd_addr import jpeg_out_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       mode420_i,
    input  logic       flush_i,
    jpeg_rd_if.addr_mp rd
);

    logic [RAM_ADDR_W-1:0] lin_ptr_q;
    logic [RAM_ADDR_W-1:0] cx_idx_q;
    logic [SLOT_W-1:0]     slot_q;
    logic                  cx_wrap;

    logic [1:0]            cx_quad;
    logic [2:0]            cx_row;
    logic [2:0]            cx_col;
    ram_addr_t             lin_addr;
    ram_addr_t             cx_addr;

    // ----------------------------------------
    // Counters
    // ----------------------------------------
    assign cx_wrap = (cx_idx_q == RAM_ADDR_W'(CX_OUT_PER_BLOCK - 1));

    always_ff @(posedge clk_i)
    begin
        if (rst_i || flush_i)
        begin
            lin_ptr_q <= '0;
            cx_idx_q  <= '0;
            slot_q    <= '0;
        end
        else if (rd.fetch)
        begin
            lin_ptr_q <= lin_ptr_q + 1'b1;
            cx_idx_q  <= cx_idx_q + 1'b1;
            if (cx_wrap)
                slot_q <= slot_q + 1'b1;
        end
    end

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    // Output index k = {quadrant, row, column} of the 16x16 block
    assign cx_quad = cx_idx_q[7:6];
    assign cx_row  = cx_idx_q[5:3];
    assign cx_col  = cx_idx_q[2:0];

    always_comb
    begin
        lin_addr.linear = lin_ptr_q;

        // Halve row and column, quadrant picks the upper or right half
        cx_addr.blk.slot   = slot_q;
        cx_addr.blk.sample = {cx_quad[1], cx_row[2:1], cx_quad[0], cx_col[2:1]};

        rd.rd_addr = mode420_i ? cx_addr : lin_addr;
    end

endmodule

//--- jpeg_out_ram.sv
/*
 * 256x32 sample store with one write port and one registered read port.
 * Read data appears one cycle after a fetch and holds until the next.
 */
`timescale 1ns/1ps

module jpeg_out_ram import jpeg_out_pkg::*;
(
    input  logic              clk_i,
    input  logic              wr_i,
    input  ram_addr_t         wr_addr_i,
    input  logic [DATA_W-1:0] wr_data_i,
    jpeg_rd_if.ram_mp         rd
);

    logic [DATA_W-1:0] mem [RAM_DEPTH];

    always_ff @(posedge clk_i)
    begin
        if (wr_i)
            mem[wr_addr_i.linear] <= wr_data_i;
    end

    // Enable-gated read register, maps onto block RAM output
    always_ff @(posedge clk_i)
    begin
        if (rd.fetch)
            rd.rd_data <= mem[rd.rd_addr.linear];
    end

endmodule

//--- jpeg_out_skid.sv
/*
 * Output stage. Issues RAM fetches against the level, lands read data in
 * an output register with a skid behind it, and drives the valid/yumi port.
 */
`timescale 1ns/1ps

module jpeg_out_skid import jpeg_out_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              flush_i,
    input  logic              yumi_i,
    output logic [DATA_W-1:0] data_out_o,
    output logic              v_o,
    jpeg_rd_if.out_mp         rd
);

    logic [LEVEL_W-1:0] outstanding_q;
    logic               inflight_q;
    logic               out_v_q;
    logic [DATA_W-1:0]  out_data_q;
    logic               skid_v_q;
    logic [DATA_W-1:0]  skid_data_q;

    logic [1:0]         held;
    logic               out_load;
    logic               skid_load;

    // ----------------------------------------
    // Fetch control
    // ----------------------------------------
    assign rd.accept = out_v_q && yumi_i;

    // Words in the RAM pipe plus both registers
    assign held = 2'(inflight_q) + 2'(out_v_q) + 2'(skid_v_q);

    assign rd.fetch = (outstanding_q < rd.level) && ((held < 2'd2) || rd.accept);

    always_ff @(posedge clk_i)
    begin
        if (rst_i || flush_i)
        begin
            outstanding_q <= '0;
            inflight_q    <= 1'b0;
        end
        else
        begin
            outstanding_q <= outstanding_q + LEVEL_W'(rd.fetch) - LEVEL_W'(rd.accept);
            inflight_q    <= rd.fetch;
        end
    end

    // ----------------------------------------
    // Output and skid registers
    // ----------------------------------------
    // Output register refills when empty or draining this cycle
    assign out_load  = !out_v_q || rd.accept;
    // Arriving word parks in the skid when output is stalled
    assign skid_load = inflight_q && !out_load;

    always_ff @(posedge clk_i)
    begin
        if (rst_i || flush_i)
        begin
            out_v_q  <= 1'b0;
            skid_v_q <= 1'b0;
        end
        else if (out_load)
        begin
            // Skid holds the older word, it goes out first
            out_v_q  <= skid_v_q || inflight_q;
            skid_v_q <= skid_v_q && inflight_q;
        end
        else if (skid_load)
            skid_v_q <= 1'b1;
    end

    always_ff @(posedge clk_i)
    begin
        if (out_load)
        begin
            if (skid_v_q)
            begin
                out_data_q  <= skid_data_q;
                skid_data_q <= rd.rd_data;
            end
            else
                out_data_q <= rd.rd_data;
        end
        else if (skid_load)
            skid_data_q <= rd.rd_data;
    end

    assign v_o        = out_v_q;
    assign data_out_o = out_data_q;

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_stall_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        v_o && !yumi_i && !flush_i |=> v_o && $stable(data_out_o));

    // Fetches are bounded by the level held in the counter block
    a_fetch_in_level: assert property (@(posedge clk_i) disable iff (rst_i)
        rd.fetch |=> outstanding_q <= rd.level);

    a_skid_free: assert property (@(posedge clk_i) disable iff (rst_i)
        skid_load |-> !skid_v_q);

endmodule

//--- jpeg_out_cx_buf.sv
/*
 * JPEG decoder output reorder buffer. Samples are written by block index,
 * read out in linear or 4:2:0 upsampled order on a valid/yumi stream.
 */
`timescale 1ns/1ps

module jpeg_out_cx_buf import jpeg_out_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic [SAMPLE_IDX_W-1:0] wr_idx_i,
    input  logic [DATA_W-1:0]       data_in_i,
    input  logic                    push_i,
    input  logic                    mode420_i,
    input  logic                    yumi_i,
    input  logic                    flush_i,

    output logic [DATA_W-1:0]       data_out_o,
    output logic                    v_o,
    output logic [LEVEL_W-1:0]      level_o
);

    jpeg_rd_if rd_bus ();

    logic [RAM_ADDR_W-1:0] wr_ptr_q;
    ram_addr_t             wr_addr;

    // ----------------------------------------
    // Write side
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i || flush_i)
            wr_ptr_q <= '0;
        else if (push_i)
            wr_ptr_q <= wr_ptr_q + 1'b1;
    end

    // Slot from the pointer's top bits, sample from the writer
    always_comb
    begin
        wr_addr.blk.slot   = wr_ptr_q[RAM_ADDR_W-1 -: SLOT_W];
        wr_addr.blk.sample = wr_idx_i;
    end

    // ----------------------------------------
    // Read path
    // ----------------------------------------
    jpeg_out_level i_level (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .push_i    (push_i),
        .mode420_i (mode420_i),
        .flush_i   (flush_i),
        .rd        (rd_bus.level_mp)
    );

    jpeg_out_rd_addr i_rd_addr (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .mode420_i (mode420_i),
        .flush_i   (flush_i),
        .rd        (rd_bus.addr_mp)
    );

    jpeg_out_ram i_ram (
        .clk_i     (clk_i),
        .wr_i      (push_i),
        .wr_addr_i (wr_addr),
        .wr_data_i (data_in_i),
        .rd        (rd_bus.ram_mp)
    );

    jpeg_out_skid i_skid (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .flush_i    (flush_i),
        .yumi_i     (yumi_i),
        .data_out_o (data_out_o),
        .v_o        (v_o),
        .rd         (rd_bus.out_mp)
    );

    assign level_o = rd_bus.level;

endmodule

//--- tb_jpeg_out_cx_buf.sv
/*
 * Directed testbench for the JPEG output reorder buffer. Runs linear,
 * back-pressure, 4:2:0 and flush streams against a queue reference model.
 */
`timescale 1ns/1ps

module tb_jpeg_out_cx_buf import jpeg_out_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    // Pushes plus reads over all tests
    localparam int TOTAL_OPS  = 2 * 64 + 2 * 128 + 64 + 256 + 40 + 10 + 2 * 32;
    localparam int TIMEOUT_NS = (10 * TOTAL_OPS + RESET_CYCLES) * CLK_PERIOD;

    logic                    clk_i;
    logic                    rst_i;
    logic [SAMPLE_IDX_W-1:0] wr_idx_i;
    logic [DATA_W-1:0]       data_in_i;
    logic                    push_i;
    logic                    mode420_i;
    logic                    yumi_i;
    logic                    flush_i;
    logic [DATA_W-1:0]       data_out_o;
    logic                    v_o;
    logic [LEVEL_W-1:0]      level_o;

    logic [31:0]             rng_state = 32'd65;
    logic [DATA_W-1:0]       exp_q [$];
    int                      err_count  = 0;
    int                      pass_count = 0;
    int                      fail_count = 0;

    jpeg_out_cx_buf i_dut (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wr_idx_i   (wr_idx_i),
        .data_in_i  (data_in_i),
        .push_i     (push_i),
        .mode420_i  (mode420_i),
        .yumi_i     (yumi_i),
        .flush_i    (flush_i),
        .data_out_o (data_out_o),
        .v_o        (v_o),
        .level_o    (level_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: the output stream did not finish in time");
        $display("Something failed");
        $finish;
    end

    // ----------------------------------------
    // Helpers and checks
    // ----------------------------------------
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp)
        begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_level(input string name, input logic [LEVEL_W-1:0] exp,
                               input logic [LEVEL_W-1:0] act);
        if (act !== exp)
        begin
            $display("MISMATCH %s: expected level %0d, actual %0d", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before)
        begin
            pass_count++;
            $display("[PASS] %s", name);
        end
        else
        begin
            fail_count++;
            $display("[FAIL] %s with %0d errors", name, err_count - errs_before);
        end
    endtask

    // Empties the buffer and selects the read mode for the next stream
    task automatic flush_buffer(input string name, input logic mode);
        @(negedge clk_i);
        flush_i   = 1'b1;
        push_i    = 1'b0;
        yumi_i    = 1'b0;
        mode420_i = mode;
        @(negedge clk_i);
        flush_i = 1'b0;
        check_bit(name, 1'b0, v_o);
        check_level(name, '0, level_o);
    endtask

    // Pushes n_push words and collects outputs until the model is empty
    // yumi_mode 0 holds yumi high, 1 draws it at random, 2 waits for pushes
    task automatic run_stream(input string name, input int n_push, input logic cx_mode,
                              input int yumi_mode, input int stop_after);
        int                pushed;
        int                accepted;
        int                lvl_exp;
        int                idx;
        int                q;
        int                r;
        int                c;
        logic              yumi_next;
        logic              stall_q;
        logic [31:0]       rnd;
        logic [DATA_W-1:0] word;
        logic [DATA_W-1:0] held_word;
        logic [DATA_W-1:0] blk [64];

        pushed   = 0;
        accepted = 0;
        lvl_exp  = 0;
        stall_q  = 1'b0;
        exp_q.delete();
        while ((pushed < n_push || exp_q.size() != 0) && accepted < stop_after)
        begin
            @(negedge clk_i);
            check_level(name, LEVEL_W'(lvl_exp), level_o);
            if (stall_q)
            begin
                check_bit(name, 1'b1, v_o);
                check_data(name, held_word, data_out_o);
            end

            case (yumi_mode)
                0: yumi_next = 1'b1;
                1:
                begin
                    rnd       = next_rand();
                    yumi_next = rnd[0];
                end
                default: yumi_next = (pushed == n_push);
            endcase
            yumi_i = yumi_next;

            // Word on the port now is taken at the next rising edge
            if (v_o && yumi_next)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("%s: DUT delivered a word that was never expected", name);
                    err_count++;
                end
                else
                begin
                    word = exp_q.pop_front();
                    check_data(name, word, data_out_o);
                end
                accepted++;
                lvl_exp--;
            end
            stall_q   = v_o && !yumi_next;
            held_word = data_out_o;

            if (pushed < n_push)
            begin
                word      = next_rand();
                idx       = cx_mode ? (pushed * 37) % 64 : pushed % 64;
                push_i    = 1'b1;
                wr_idx_i  = SAMPLE_IDX_W'(idx);
                data_in_i = word;
                if (cx_mode)
                    blk[idx] = word;
                else
                    exp_q.push_back(word);
                pushed++;
                lvl_exp += cx_mode ? CX_UPSAMPLE : 1;

                // Upsampled order: quadrant picks the half, row and column halve
                if (cx_mode && pushed == n_push)
                begin
                    for (int k = 0; k < CX_OUT_PER_BLOCK; k++)
                    begin
                        q = k / 64;
                        r = (k / 8) % 8;
                        c = k % 8;
                        exp_q.push_back(blk[(r / 2 + 4 * (q / 2)) * 8 + c / 2 + 4 * (q % 2)]);
                    end
                end
            end
            else
                push_i = 1'b0;
        end

        @(negedge clk_i);
        push_i = 1'b0;
        yumi_i = 1'b0;
        check_level(name, LEVEL_W'(lvl_exp), level_o);
        if (pushed == n_push && exp_q.size() == 0)
            check_bit(name, 1'b0, v_o);
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic test_reset_state();
        int errs_before;

        errs_before = err_count;
        @(negedge clk_i);
        check_bit("reset_state", 1'b0, v_o);
        check_level("reset_state", '0, level_o);
        report_test("reset_state", errs_before);
    endtask

    task automatic test_linear_stream();
        int errs_before;

        errs_before = err_count;
        flush_buffer("linear_stream", 1'b0);
        run_stream("linear_stream", 64, 1'b0, 0, 1 << 20);
        report_test("linear_stream", errs_before);
    endtask

    task automatic test_back_pressure();
        int errs_before;

        errs_before = err_count;
        flush_buffer("back_pressure", 1'b0);
        run_stream("back_pressure", 128, 1'b0, 1, 1 << 20);
        report_test("back_pressure", errs_before);
    endtask

    task automatic test_upsample_420();
        int errs_before;

        errs_before = err_count;
        flush_buffer("upsample_420", 1'b1);
        // Level reaches 256 before the first accept, checked each cycle
        run_stream("upsample_420", 64, 1'b1, 2, 1 << 20);
        flush_buffer("upsample_420", 1'b0);
        report_test("upsample_420", errs_before);
    endtask

    task automatic test_flush();
        int errs_before;

        errs_before = err_count;
        flush_buffer("flush", 1'b0);
        run_stream("flush", 40, 1'b0, 0, 10);
        flush_buffer("flush", 1'b0);
        // Fresh stream must start again from slot 0
        run_stream("flush", 32, 1'b0, 0, 1 << 20);
        report_test("flush", errs_before);
    endtask

    initial
    begin
        rst_i     = 1'b1;
        wr_idx_i  = '0;
        data_in_i = '0;
        push_i    = 1'b0;
        mode420_i = 1'b0;
        yumi_i    = 1'b0;
        flush_i   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        test_reset_state();
        test_linear_stream();
        test_back_pressure();
        test_upsample_420();
        test_flush();

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- vlog.f
jpeg_out_pkg.sv
jpeg_rd_if.sv
jpeg_out_level.sv
jpeg_out_rd_addr.sv
jpeg_out_ram.sv
jpeg_out_skid.sv
jpeg_out_cx_buf.sv
tb_jpeg_out_cx_buf.sv
